//--- verilog/load_pkg.sv
// ========================================
// Shared widths, sizes and types of the load tile
// Beat width is fixed by the read master at 128 bits
// Base address must be 16-byte aligned, length at least one word
// ========================================

package load_pkg;

    // Bus and counter widths
    localparam int ADDR_W = 32;
    localparam int LEN_W = 12;
    localparam int WORD_W = 32;
    localparam int BEAT_W = 128;
    localparam int LEN_BYTES_W = 6;

    // Beat and burst geometry
    localparam int WORDS_PER_BEAT = BEAT_W / WORD_W;
    localparam int BLEN = 8;
    localparam int RMST_BUF_WORDS = 64;

    // Output word FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // Sized copies for compares against word counters
    localparam logic [LEN_W-1:0] BLEN_LEN = LEN_W'(BLEN);
    localparam logic [LEN_W-1:0] BUF_LIMIT = LEN_W'(RMST_BUF_WORDS);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BEAT_W-1:0] beat_t;

    // Burst issue FSM
    typedef enum logic [2:0] {
        IDLE,
        ARMED,
        ISSUE,
        WAIT_ACK,
        WAIT_DONE
    } load_state_t;

    // Transfer configuration, 44 bits
    typedef struct packed {
        logic [ADDR_W-1:0] raddr;
        logic [LEN_W-1:0]  iolen;
    } load_cfg_t;

    // Command toward the read master
    typedef struct packed {
        logic [ADDR_W-1:0]      base;
        logic [LEN_BYTES_W-1:0] len_bytes;
        logic                   go;
    } rd_cmd_t;

endpackage

//--- verilog/burst_ctrl.sv
// ========================================
// Burst issue FSM toward the read master
// Bursts go out in address order, one at a time
// The next burst waits for an idle master and buffer credit
// ========================================
`timescale 1ns/1ps

module burst_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  load_pkg::load_cfg_t        cfg,
    input  logic                       cfg_valid,
    input  logic                       load_start,
    input  logic                       rmst_done,
    input  logic                       fits,
    input  logic [load_pkg::LEN_W-1:0] words_left,
    input  logic                       xfer_done,
    output load_pkg::rd_cmd_t          rd_cmd,
    output logic [load_pkg::LEN_W-1:0] iolen,
    output logic [load_pkg::LEN_W-1:0] burst_words
);

    load_pkg::load_state_t state;
    load_pkg::load_state_t state_nxt;

    // Byte address of the next burst
    logic [load_pkg::ADDR_W-1:0] next_addr;
    logic [load_pkg::ADDR_W-1:0] burst_bytes;
    logic                        can_issue;

    // Full burst unless fewer words remain
    assign burst_words = (words_left > load_pkg::BLEN_LEN) ? load_pkg::BLEN_LEN : words_left;

    // Words to bytes, zero extended to the address width
    assign burst_bytes = {{(load_pkg::ADDR_W - load_pkg::LEN_W - 2){1'b0}}, burst_words, 2'b00};

    // Master idle, work left and room in its buffer
    assign can_issue = rmst_done && (words_left != '0) && fits;

    always_comb begin
        rd_cmd.base = next_addr;
        // At most BLEN words, so 6 bits of bytes
        rd_cmd.len_bytes = {burst_words[load_pkg::LEN_BYTES_W-3:0], 2'b00};
        rd_cmd.go = (state == load_pkg::ISSUE);
    end

    always_comb begin
        state_nxt = state;
        case (state)
            load_pkg::IDLE: begin
                if (load_start) begin
                    state_nxt = load_pkg::ARMED;
                end
            end
            load_pkg::ARMED: begin
                if (can_issue) begin
                    state_nxt = load_pkg::ISSUE;
                end
            end
            // go is high here for exactly one cycle
            load_pkg::ISSUE: begin
                state_nxt = load_pkg::WAIT_ACK;
            end
            // Master drops done the cycle after go
            load_pkg::WAIT_ACK: begin
                if (xfer_done) begin
                    state_nxt = load_pkg::IDLE;
                end else if (!rmst_done) begin
                    state_nxt = load_pkg::WAIT_DONE;
                end
            end
            load_pkg::WAIT_DONE: begin
                if (xfer_done) begin
                    state_nxt = load_pkg::IDLE;
                end else if (can_issue) begin
                    state_nxt = load_pkg::ISSUE;
                end
            end
            default: begin
                state_nxt = load_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= load_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Configuration latch and address walk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_addr <= '0;
            iolen <= '0;
        end else if (cfg_valid) begin
            next_addr <= cfg.raddr;
            iolen <= cfg.iolen;
        end else if (rd_cmd.go) begin
            next_addr <= next_addr + burst_bytes;
        end
    end

endmodule

//--- verilog/credit_counter.sv
// ========================================
// Word bookkeeping for one transfer
// Counters restart only on a configuration strobe
// ========================================
`timescale 1ns/1ps

module credit_counter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_valid,
    input  load_pkg::load_cfg_t        cfg,
    input  logic                       cmd_go,
    input  logic [load_pkg::LEN_W-1:0] burst_words,
    input  logic                       word_push,
    output logic                       fits,
    output logic [load_pkg::LEN_W-1:0] words_left,
    output logic                       xfer_done
);

    // Words asked of the master and words already unpacked
    logic [load_pkg::LEN_W-1:0] req_cnt;
    logic [load_pkg::LEN_W-1:0] unp_cnt;
    logic [load_pkg::LEN_W-1:0] iolen_q;
    logic [load_pkg::LEN_W-1:0] in_flight;
    logic                       last_push;

    // Words fetched or pending in the master but not yet unpacked
    assign in_flight = req_cnt - unp_cnt;

    // Another full burst must still fit in the master buffer
    assign fits = (in_flight + load_pkg::BLEN_LEN) <= load_pkg::BUF_LIMIT;

    assign last_push = word_push && (unp_cnt + 1'b1 == iolen_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_cnt <= '0;
            words_left <= '0;
            iolen_q <= '0;
        end else if (cfg_valid) begin
            req_cnt <= '0;
            words_left <= cfg.iolen;
            iolen_q <= cfg.iolen;
        end else if (cmd_go) begin
            req_cnt <= req_cnt + burst_words;
            words_left <= words_left - burst_words;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            unp_cnt <= '0;
            xfer_done <= 1'b0;
        end else if (cfg_valid) begin
            unp_cnt <= '0;
            xfer_done <= 1'b0;
        end else begin
            if (word_push) begin
                unp_cnt <= unp_cnt + 1'b1;
            end
            // One pulse, the cycle after the final word enters the FIFO
            xfer_done <= last_push;
        end
    end

endmodule

//--- verilog/beat_unpacker.sv
// ========================================
// Splits 128-bit beats into 32-bit words, lowest word first
// Pad words after the transfer's last word are dropped
// ========================================
`timescale 1ns/1ps

module beat_unpacker (
    input  logic                       clk,
    input  logic                       rst,
    input  load_pkg::beat_t            rmst_data,
    input  logic                       rmst_avail,
    input  logic                       fifo_full,
    input  logic [load_pkg::LEN_W-1:0] iolen,
    input  logic                       cfg_valid,
    output logic                       rmst_pop,
    output logic                       push,
    output load_pkg::word_t            word
);

    // One-hot pointer to the word within the head beat
    logic [load_pkg::WORDS_PER_BEAT-1:0] sel;
    // Words of the transfer taken so far
    logic [load_pkg::LEN_W-1:0]          word_idx;
    load_pkg::word_t                     word_nxt;
    logic                                active;
    logic                                last_word;
    logic                                take;

    assign active = (word_idx != iolen);
    assign last_word = (word_idx == iolen - 1'b1);

    // Stall on a full FIFO, nothing taken once the transfer is complete
    assign take = rmst_avail && !fifo_full && active;

    // Release the beat after its top word or after the final word
    assign rmst_pop = take && (sel[load_pkg::WORDS_PER_BEAT-1] || last_word);

    always_comb begin
        word_nxt = '0;
        for (int i = 0; i < load_pkg::WORDS_PER_BEAT; i++) begin
            if (sel[i]) begin
                word_nxt = rmst_data[i*load_pkg::WORD_W +: load_pkg::WORD_W];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= {{(load_pkg::WORDS_PER_BEAT-1){1'b0}}, 1'b1};
            word_idx <= '0;
        end else if (cfg_valid) begin
            sel <= {{(load_pkg::WORDS_PER_BEAT-1){1'b0}}, 1'b1};
            word_idx <= '0;
        end else if (take) begin
            word_idx <= word_idx + 1'b1;
            if (rmst_pop) begin
                // Next beat starts at word 0
                sel <= {{(load_pkg::WORDS_PER_BEAT-1){1'b0}}, 1'b1};
            end else begin
                sel <= {sel[load_pkg::WORDS_PER_BEAT-2:0], sel[load_pkg::WORDS_PER_BEAT-1]};
            end
        end
    end

    // Output register, word lands in the FIFO one cycle after the take
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            word <= word_nxt;
        end
    end

endmodule

//--- verilog/word_fifo.sv
// ========================================
// Word FIFO toward the compute logic
// full rises one entry early to cover the unpacker output register
// Head word is read combinationally
// ========================================
`timescale 1ns/1ps

module word_fifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  load_pkg::word_t word,
    input  logic            pop,
    output load_pkg::word_t out_data,
    output logic            out_valid,
    output logic            full
);

    load_pkg::word_t mem [load_pkg::FIFO_DEPTH];

    logic [load_pkg::FIFO_AW-1:0] wr_ptr;
    logic [load_pkg::FIFO_AW-1:0] rd_ptr;
    logic [load_pkg::FIFO_AW:0]   count;
    logic                         pop_en;
    logic                         push_en;

    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    // Pops only count when a word is present
    assign pop_en = pop && out_valid;

    // Never overwrite a live entry, a same-cycle pop frees one
    assign push_en = push && ((count != (load_pkg::FIFO_AW+1)'(load_pkg::FIFO_DEPTH)) || pop_en);

    // Room for the word already held in the unpacker
    assign full = (count >= (load_pkg::FIFO_AW+1)'(load_pkg::FIFO_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr] <= word;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged when push and pop coincide
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push_en, pop_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/load_tile_top.sv
// ========================================
// Load tile top level
// External bus and read master sit outside this tile
// ========================================
`timescale 1ns/1ps

module load_tile_top (
    input  logic                clk,
    input  logic                rst,
    // Configuration and start
    input  load_pkg::load_cfg_t cfg,
    input  logic                cfg_valid,
    input  logic                load_start,
    // Read master
    output load_pkg::rd_cmd_t   rd_cmd,
    input  logic                rmst_done,
    input  load_pkg::beat_t     rmst_data,
    input  logic                rmst_avail,
    output logic                rmst_pop,
    // Compute side
    output load_pkg::word_t     out_data,
    output logic                out_valid,
    input  logic                out_pop,
    output logic                load_done
);

    logic                       fits;
    logic [load_pkg::LEN_W-1:0] words_left;
    logic [load_pkg::LEN_W-1:0] burst_words;
    logic [load_pkg::LEN_W-1:0] iolen;
    logic                       push;
    load_pkg::word_t            word;
    logic                       fifo_full;

    burst_ctrl u_burst_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .cfg_valid   (cfg_valid),
        .load_start  (load_start),
        .rmst_done   (rmst_done),
        .fits        (fits),
        .words_left  (words_left),
        .xfer_done   (load_done),
        .rd_cmd      (rd_cmd),
        .iolen       (iolen),
        .burst_words (burst_words)
    );

    // Completion pulse doubles as the tile's load_done
    credit_counter u_credit_counter (
        .clk         (clk),
        .rst         (rst),
        .cfg_valid   (cfg_valid),
        .cfg         (cfg),
        .cmd_go      (rd_cmd.go),
        .burst_words (burst_words),
        .word_push   (push),
        .fits        (fits),
        .words_left  (words_left),
        .xfer_done   (load_done)
    );

    beat_unpacker u_beat_unpacker (
        .clk        (clk),
        .rst        (rst),
        .rmst_data  (rmst_data),
        .rmst_avail (rmst_avail),
        .fifo_full  (fifo_full),
        .iolen      (iolen),
        .cfg_valid  (cfg_valid),
        .rmst_pop   (rmst_pop),
        .push       (push),
        .word       (word)
    );

    word_fifo u_word_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .word      (word),
        .pop       (out_pop),
        .out_data  (out_data),
        .out_valid (out_valid),
        .full      (fifo_full)
    );

endmodule

//--- dv/tb_load_tile.sv
// ========================================
// Read master and external memory are modelled in this testbench
// Master buffer holds 64 words and done rises a fixed delay after go
// Memory word at byte address a equals a XOR 32'hA5A5_0000
// ========================================
`timescale 1ns/1ps

module tb_load_tile;

    // Cycles from go until the modelled master reports the burst fetched
    localparam int DONE_DELAY = 6;
    localparam int TOTAL_WORDS = 3 + 32 + 37 + 9;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 50 + 200;

    logic                clk;
    logic                rst;
    load_pkg::load_cfg_t cfg;
    logic                cfg_valid;
    logic                load_start;
    load_pkg::rd_cmd_t   rd_cmd;
    logic                rmst_done = 1'b1;
    load_pkg::beat_t     rmst_data = '0;
    logic                rmst_avail = 1'b0;
    logic                rmst_pop;
    load_pkg::word_t     out_data;
    logic                out_valid;
    logic                out_pop = 1'b0;
    logic                load_done;

    // Transfer under test as seen by the checkers
    logic [31:0] cur_base;
    int          cur_len;
    int          rx_cnt;
    int          done_count;
    int          err_cnt;
    // 0 no pops, 1 pop every cycle, 2 sparse pops from the LFSR
    int          pop_mode;
    logic [31:0] lfsr;

    // Read master model state
    load_pkg::beat_t   beat_q[$];
    load_pkg::rd_cmd_t cmd_log[$];
    load_pkg::rd_cmd_t cmd_s;
    logic              pop_s;
    logic              cfg_s;
    int                done_timer;

    load_tile_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .cfg_valid  (cfg_valid),
        .load_start (load_start),
        .rd_cmd     (rd_cmd),
        .rmst_done  (rmst_done),
        .rmst_data  (rmst_data),
        .rmst_avail (rmst_avail),
        .rmst_pop   (rmst_pop),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_pop    (out_pop),
        .load_done  (load_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // External memory contents
    function automatic load_pkg::word_t mem_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic check_word(input string name, input load_pkg::word_t got,
                              input load_pkg::word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_cmd(input load_pkg::rd_cmd_t got, input load_pkg::rd_cmd_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: rd_cmd got base %h len_bytes %h, exp base %h len_bytes %h",
                     got.base, got.len_bytes, exp.base, exp.len_bytes);
        end
    endtask

    task automatic check_done(input int got, input int exp);
        if (got != exp) begin
            err_cnt++;
            $display("** Error: load_done pulses got %h exp %h", got, exp);
        end
    endtask

    task automatic check_low(input string name, input logic val);
        if (val !== 1'b0) begin
            err_cnt++;
            $display("** Error: %s got %h exp 0 at %0t", name, val, $time);
        end
    endtask

    task automatic fail_note(input string what);
        err_cnt++;
        $display("Failure: %s at %0t", what, $time);
    endtask

    // Queue the beats of one burst with the last beat padded by the memory words after it
    task automatic queue_burst(input load_pkg::rd_cmd_t cmd);
        int              n_words;
        int              n_beats;
        load_pkg::beat_t b;
        n_words = int'(cmd.len_bytes) / 4;
        n_beats = (n_words + load_pkg::WORDS_PER_BEAT - 1) / load_pkg::WORDS_PER_BEAT;
        for (int k = 0; k < n_beats; k++) begin
            for (int i = 0; i < load_pkg::WORDS_PER_BEAT; i++) begin
                b[i*load_pkg::WORD_W +: load_pkg::WORD_W] = mem_word(cmd.base + 32'(16*k + 4*i));
            end
            beat_q.push_back(b);
        end
    endtask

    // Read master model samples at the edge and answers 1 ns later
    always @(posedge clk) begin
        if (!rst) begin
            cmd_s = rd_cmd;
            pop_s = rmst_pop;
            cfg_s = cfg_valid;
            #1;
            if (cfg_s) begin
                cmd_log.delete();
            end
            if (pop_s) begin
                if (beat_q.size() == 0) begin
                    fail_note("read master popped with an empty buffer");
                end else begin
                    beat_q.delete(0);
                end
            end
            if (cmd_s.go) begin
                cmd_log.push_back(cmd_s);
                queue_burst(cmd_s);
                rmst_done = 1'b0;
                done_timer = DONE_DELAY;
            end else if (!rmst_done) begin
                if (done_timer > 1) begin
                    done_timer--;
                end else begin
                    rmst_done = 1'b1;
                end
            end
            if (beat_q.size() * load_pkg::WORDS_PER_BEAT > load_pkg::RMST_BUF_WORDS) begin
                fail_note("read master buffer holds more than 64 words");
            end
            rmst_avail = (beat_q.size() != 0);
            rmst_data = rmst_avail ? beat_q[0] : '0;
        end
    end

    // Output monitor restarts its counters with each configuration
    always @(posedge clk) begin
        if (!rst) begin
            if (cfg_valid) begin
                rx_cnt = 0;
                done_count = 0;
            end
            if (out_valid && out_pop) begin
                if (rx_cnt >= cur_len) begin
                    fail_note("word delivered beyond the transfer length");
                end else begin
                    check_word("out_data", out_data, mem_word(cur_base + 32'(4*rx_cnt)));
                end
                rx_cnt++;
            end
            if (load_done) begin
                done_count++;
            end
        end
    end

    // Two LFSR bits per cycle make the consumer pop about a quarter of the time
    always @(posedge clk) begin
        logic b0;
        logic b1;
        #1;
        if (pop_mode == 2) begin
            b0 = lfsr_step();
            b1 = lfsr_step();
            out_pop = b0 & b1;
        end else begin
            out_pop = (pop_mode == 1);
        end
    end

    task automatic report_test(input string name, input int err_start);
        $display("[%s] %s, %0d errors", name,
                 (err_cnt == err_start) ? "ok" : "failed", err_cnt - err_start);
    endtask

    task automatic reset_state_test();
        int err_start;
        err_start = err_cnt;
        repeat (20) begin
            @(posedge clk);
            check_low("rd_cmd.go", rd_cmd.go);
            check_low("rmst_pop", rmst_pop);
            check_low("out_valid", out_valid);
            check_low("load_done", load_done);
        end
        report_test("reset_state", err_start);
    endtask

    task automatic run_transfer(input string name, input logic [31:0] base,
                                input int len, input int mode);
        int                err_start;
        int                n_cmd;
        int                w;
        load_pkg::rd_cmd_t exp;
        err_start = err_cnt;
        @(posedge clk);
        #1;
        cur_base = base;
        cur_len = len;
        pop_mode = mode;
        cfg.raddr = base;
        cfg.iolen = load_pkg::LEN_W'(len);
        cfg_valid = 1'b1;
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
        load_start = 1'b1;
        @(posedge clk);
        #1;
        load_start = 1'b0;
        // Wait for every word and the done pulse
        while (rx_cnt < len || done_count == 0) begin
            @(posedge clk);
            #2;
        end
        // Quiet period to catch stray words or a second done pulse
        repeat (8) @(posedge clk);
        #2;
        pop_mode = 0;
        check_done(done_count, 1);
        n_cmd = (len + load_pkg::BLEN - 1) / load_pkg::BLEN;
        if (cmd_log.size() != n_cmd) begin
            fail_note($sformatf("expected %0d commands, saw %0d", n_cmd, cmd_log.size()));
        end else begin
            for (int c = 0; c < n_cmd; c++) begin
                w = len - c * load_pkg::BLEN;
                if (w > load_pkg::BLEN) begin
                    w = load_pkg::BLEN;
                end
                exp.base = base + 32'(4 * c * load_pkg::BLEN);
                exp.len_bytes = load_pkg::LEN_BYTES_W'(4 * w);
                exp.go = 1'b1;
                check_cmd(cmd_log[c], exp);
            end
        end
        if (beat_q.size() != 0) begin
            fail_note("beats left in the read master after the transfer");
        end
        report_test(name, err_start);
    endtask

    initial begin
        rst = 1'b1;
        cfg = '0;
        cfg_valid = 1'b0;
        load_start = 1'b0;
        err_cnt = 0;
        rx_cnt = 0;
        done_count = 0;
        cur_base = '0;
        cur_len = 0;
        pop_mode = 0;
        done_timer = 0;
        lfsr = 32'd88679;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_state_test();
        run_transfer("short_transfer", 32'h0000_1000, 3, 1);
        run_transfer("multi_burst", 32'h0000_2000, 32, 1);
        run_transfer("odd_len_backpressure", 32'h0000_4000, 37, 2);
        run_transfer("reconfigure", 32'h0000_8000, 9, 1);
        $display("Tests run 5, errors %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the total words moved by all tests
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a transfer never finished",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src.f
verilog/load_pkg.sv
verilog/burst_ctrl.sv
verilog/credit_counter.sv
verilog/beat_unpacker.sv
verilog/word_fifo.sv
verilog/load_tile_top.sv
dv/tb_load_tile.sv

//--- Makefile
TOOL      = verilator
TOP       = tb_load_tile
RTL_TOP   = load_tile_top
FILELIST  = src.f
FLAGS     = --timing
SIM_FLAGS = --binary -j 0 -Mdir obj_dir
LOG       = sim.log
PASS_MSG  = TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(FLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
